// ==== bench/spinnlink_sva.sv ====
// link protocol assertions, bound into every spinnlink_sender instance
`timescale 1ns/10ps
`include "spinnlink_settings.svh"

module spinnlink_sva (
  input logic                      CLK_IN,
  input logic                      RESET_IN,
  input logic [`SPL_CODE_BITS-1:0] link_data,
  input logic                      link_ack,
  input logic                      pkt_rdy
);

  logic [`SPL_CODE_BITS-1:0] data_d;       // wires one edge back
  logic                      ack_d;        // ack one edge back
  logic                      ack_at_send;  // ack level the last symbol went out on
  logic                      sent_any;     // no symbol yet after reset
  logic                      wire_change;

  assign wire_change = (link_data != data_d);

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      data_d      <= '0;  // sender reset level
      ack_d       <= 1'b0;
      ack_at_send <= 1'b0;
      sent_any    <= 1'b0;
    end else begin
      data_d <= link_data;
      ack_d  <= link_ack;
      if (wire_change) begin
        ack_at_send <= ack_d;  // sender decided on the ack it saw last edge
        sent_any    <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // link wire rules
  // ----------------------------------------------------------
  two_wire_flip: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    wire_change |-> ($countones(link_data ^ data_d) == 2))
    else $error("link_data change does not flip exactly two wires");

  rdy_low_in_reset: assert property (@(posedge CLK_IN) RESET_IN |-> !pkt_rdy)
    else $error("pkt_rdy high during reset");

  // next symbol only once the ack has moved
  one_symbol_per_ack: assert property (@(posedge CLK_IN) disable iff (RESET_IN)
    (wire_change && sent_any) |-> (ack_d != ack_at_send))
    else $error("link_data changed twice without an ack toggle");

endmodule

bind spinnlink_sender spinnlink_sva spinnlink_sva_inst (
  .CLK_IN    (CLK_IN),
  .RESET_IN  (RESET_IN),
  .link_data (link_data),
  .link_ack  (link_ack),
  .pkt_rdy   (pkt_rdy)
);

// ==== bench/spinnlink_tb.sv ====
// directed loopback testbench for the 2-of-7 link, built from filelist.f by the sim script
`timescale 1ns/10ps
`include "spinnlink_settings.svh"

module spinnlink_tb;

  localparam int TOTAL_PKTS = 49;  // 1 + 1 + 4 + 3 + 40 over all tests

  logic                     CLK_IN;
  logic                     RESET_IN;
  logic [`SPL_PKT_BITS-1:0] pkt_data;
  logic                     pkt_vld;
  logic                     pkt_rdy;
  logic [`SPL_PKT_BITS-1:0] out_data;
  logic                     out_vld;
  logic                     out_rdy;
  logic [`SPL_PKT_BITS-1:0] exp_q[$];     // sent, not yet delivered
  integer                   seed;
  logic                     rand_rdy_on;  // random out_rdy driver active

  spinnlink_loopback_top spinnlink_loopback_top_inst (.*);

  initial begin
    CLK_IN = 1'b0;
    forever #50 CLK_IN = ~CLK_IN;  // 100 ns period
  end

  initial begin
    repeat (TOTAL_PKTS * 400) @(posedge CLK_IN);
    $display("timeout, the link stopped delivering packets");
    stop_run();
  end

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // short packets come back with only the low 40 bits
  function automatic logic [`SPL_PKT_BITS-1:0] expected_packet(
    input logic [`SPL_PKT_BITS-1:0] pkt);
    logic [`SPL_PKT_BITS-1:0] mask;
    mask = '1;
    if (!pkt[`SPL_SIZE_BIT]) mask = mask >> (`SPL_PKT_BITS - `SPL_SHORT_SYMS * `SPL_SYM_BITS);
    return pkt & mask;
  endfunction

  task automatic check_packet(input logic [`SPL_PKT_BITS-1:0] got);
    logic [`SPL_PKT_BITS-1:0] exp;
    if (exp_q.size() == 0) begin
      $display("a packet %h arrived that was never sent", got);
      stop_run();
    end else begin
      exp = exp_q.pop_front();
      if (got !== exp) begin
        $display("Fail %0t: packet expected %h got %h", $time, exp, got);
        stop_run();
      end
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s expected %b got %b", $time, what, exp, got);
      stop_run();
    end
  endtask

  always @(posedge CLK_IN) begin
    if (!RESET_IN && out_vld && out_rdy) check_packet(out_data);  // delivery edge
  end

  // ----------------------------------------------------------
  // stimulus helpers, all driving on the falling edge
  // ----------------------------------------------------------
  task automatic send_packet(input logic [`SPL_PKT_BITS-1:0] pkt);
    @(negedge CLK_IN);
    pkt_data = pkt;
    pkt_vld  = 1'b1;  // stays high until the next call or release
    while (!pkt_rdy) @(negedge CLK_IN);
    exp_q.push_back(expected_packet(pkt));  // accepted on the coming rise
    @(posedge CLK_IN);
  endtask

  task automatic release_input();
    @(negedge CLK_IN);
    pkt_vld = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge CLK_IN);
    check_flag(out_vld, 1'b0, "out_vld after last delivery");
  endtask

  task automatic random_packet(output logic [`SPL_PKT_BITS-1:0] pkt);
    logic [95:0] raw;
    raw = {$random(seed), $random(seed), $random(seed)};
    pkt = raw[`SPL_PKT_BITS-1:0];
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic test_reset();
    int waited;
    repeat (16) @(posedge CLK_IN);  // 16 rising edges in reset
    @(negedge CLK_IN);
    check_flag(pkt_rdy, 1'b0, "pkt_rdy in reset");
    RESET_IN = 1'b0;
    waited = 0;
    while (!pkt_rdy && waited < 4) begin
      @(negedge CLK_IN);
      waited++;
    end
    check_flag(pkt_rdy, 1'b1, "pkt_rdy after reset");
    check_flag(out_vld, 1'b0, "out_vld after reset");
  endtask

  task automatic test_single(input logic [`SPL_PKT_BITS-1:0] pkt);
    send_packet(pkt);
    release_input();
    wait_drained();
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 4; i++) begin
      send_packet({64'h0f1e_2d3c_4b5a_6978 ^ {16{4'(i)}}, 6'(i), i[0], 1'b0});  // bit 1 alternates
    end
    release_input();
    wait_drained();
  endtask

  task automatic test_backpressure();
    logic [`SPL_PKT_BITS-1:0] pkt;
    @(negedge CLK_IN);
    out_rdy = 1'b0;
    fork
      begin
        for (int i = 0; i < 3; i++) begin
          random_packet(pkt);
          send_packet(pkt);
        end
        release_input();
      end
      begin
        while (!out_vld) @(negedge CLK_IN);
        repeat (32) begin
          @(negedge CLK_IN);
          check_flag(pkt_rdy, 1'b0, "pkt_rdy while link stalled");
          check_flag(out_vld, 1'b1, "out_vld under back-pressure");
        end
        out_rdy = 1'b1;
      end
    join
    wait_drained();
  endtask

  task automatic test_random();
    logic [`SPL_PKT_BITS-1:0] pkts[40];
    int                       gaps[40];
    for (int i = 0; i < 40; i++) begin  // drawn up front, one $random user per phase
      random_packet(pkts[i]);
      gaps[i] = $random(seed) & 3;
    end
    rand_rdy_on = 1'b1;
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          send_packet(pkts[i]);
          if (gaps[i] != 0) begin
            release_input();
            repeat (gaps[i]) @(negedge CLK_IN);
          end
        end
        release_input();
        wait_drained();
        rand_rdy_on = 1'b0;
      end
      while (rand_rdy_on) begin
        @(negedge CLK_IN);
        out_rdy = (($random(seed) & 3) != 0);  // ready about 3 cycles in 4
      end
    join
    out_rdy = 1'b1;
  endtask

  initial begin
    seed        = 32'h6207_ad19;
    RESET_IN    = 1'b1;
    pkt_data    = '0;
    pkt_vld     = 1'b0;
    out_rdy     = 1'b1;
    rand_rdy_on = 1'b0;
    test_reset();
    test_single(72'ha5_dead_beef_1234_5698);  // short, upper bits must come back zero
    test_single(72'h3c_4567_89ab_cdef_1302);  // long
    test_back_to_back();
    test_backpressure();
    test_random();
    if (exp_q.size() != 0) begin
      $display("%0d packets were never delivered", exp_q.size());
      stop_run();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+src
src/spinnlink_pkg.sv
src/spinnlink_sender.sv
src/spinnlink_receiver.sv
src/spinnlink_loopback_top.sv
bench/spinnlink_sva.sv
bench/spinnlink_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the loopback testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module spinnlink_tb -o spinnlink_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/spinnlink_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== src/spinnlink_loopback_top.sv ====
// loopback top level, packet port into the sender and out of the receiver over one 2-of-7 link
`timescale 1ns/10ps
`include "spinnlink_settings.svh"

module spinnlink_loopback_top (
  input  logic                     CLK_IN,
  input  logic                     RESET_IN,

  // packet input
  input  logic [`SPL_PKT_BITS-1:0] pkt_data,
  input  logic                     pkt_vld,
  output logic                     pkt_rdy,

  // packet output
  output logic [`SPL_PKT_BITS-1:0] out_data,
  output logic                     out_vld,
  input  logic                     out_rdy
);

  // ----------------------------------------------------------
  // link between the two ends
  // ----------------------------------------------------------
  logic [`SPL_CODE_BITS-1:0] link_data;  // nrz 2-of-7 wires
  logic                      link_ack;   // toggles per symbol

  spinnlink_sender spinnlink_sender_inst (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .pkt_data  (pkt_data),
    .pkt_vld   (pkt_vld),
    .pkt_rdy   (pkt_rdy),
    .link_data (link_data),
    .link_ack  (link_ack)
  );

  spinnlink_receiver spinnlink_receiver_inst (
    .CLK_IN    (CLK_IN),
    .RESET_IN  (RESET_IN),
    .link_data (link_data),
    .link_ack  (link_ack),
    .out_data  (out_data),
    .out_vld   (out_vld),
    .out_rdy   (out_rdy)
  );

endmodule

// ==== src/spinnlink_pkg.sv ====
// shared link types and nrz 2-of-7 coding functions, imported by the sender and the receiver
`include "spinnlink_settings.svh"

package spinnlink_pkg;

  // sender fsm
  typedef enum logic [1:0] {
    SND_IDLE,  // waiting for a packet
    SND_TRAN,  // sending data nibbles
    SND_EOP,   // eop sent, waiting for its ack
    SND_PARK   // next packet parked behind the eop ack
  } sender_state_t;

  // receiver fsm, hold while a packet sits at the output
  typedef enum logic {
    RCV_COLLECT,
    RCV_HOLD
  } receiver_state_t;

  // kind of a decoded code word
  typedef enum logic [1:0] {
    SYM_DATA,
    SYM_EOP,
    SYM_NONE   // not a legal code
  } symbol_kind_t;

  // ----------------------------------------------------------
  // nrz encoder, two wires flip per symbol
  // ----------------------------------------------------------
  function automatic logic [`SPL_CODE_BITS-1:0] encode_2of7(
    input logic [`SPL_CODE_BITS-1:0] prev,   // current wire state
    input logic [`SPL_SYM_BITS-1:0]  value,  // nibble to send
    input logic                      eop     // send eop instead
  );
    logic [`SPL_CODE_BITS-1:0] code;
    if (eop) begin
      code = 7'b1100000;
    end else begin
      case (value)
        4'h0:    code = 7'b0010001;
        4'h1:    code = 7'b0010010;
        4'h2:    code = 7'b0010100;
        4'h3:    code = 7'b0011000;
        4'h4:    code = 7'b0100001;
        4'h5:    code = 7'b0100010;
        4'h6:    code = 7'b0100100;
        4'h7:    code = 7'b0101000;
        4'h8:    code = 7'b1000001;
        4'h9:    code = 7'b1000010;
        4'ha:    code = 7'b1000100;
        4'hb:    code = 7'b1001000;
        4'hc:    code = 7'b0000011;
        4'hd:    code = 7'b0000110;
        4'he:    code = 7'b0001100;
        default: code = 7'b0001001;  // 4'hf
      endcase
    end
    return prev ^ code;  // invert the two code wires
  endfunction

  // ----------------------------------------------------------
  // decoder, takes old ^ new wire state
  // ----------------------------------------------------------
  function automatic symbol_kind_t decode_2of7(
    input  logic [`SPL_CODE_BITS-1:0] diff,
    output logic [`SPL_SYM_BITS-1:0]  value
  );
    symbol_kind_t kind;
    kind  = SYM_DATA;
    value = '0;
    case (diff)
      7'b0010001: value = 4'h0;
      7'b0010010: value = 4'h1;
      7'b0010100: value = 4'h2;
      7'b0011000: value = 4'h3;
      7'b0100001: value = 4'h4;
      7'b0100010: value = 4'h5;
      7'b0100100: value = 4'h6;
      7'b0101000: value = 4'h7;
      7'b1000001: value = 4'h8;
      7'b1000010: value = 4'h9;
      7'b1000100: value = 4'ha;
      7'b1001000: value = 4'hb;
      7'b0000011: value = 4'hc;
      7'b0000110: value = 4'hd;
      7'b0001100: value = 4'he;
      7'b0001001: value = 4'hf;
      7'b1100000: kind  = SYM_EOP;
      default:    kind  = SYM_NONE;  // no change or illegal pattern
    endcase
    return kind;
  endfunction

endpackage

// ==== src/spinnlink_receiver.sv ====
// link receiver, decodes 2-of-7 transitions into packets on a valid/ready port and returns the ack
`timescale 1ns/10ps
`include "spinnlink_settings.svh"

module spinnlink_receiver
  import spinnlink_pkg::*;
(
  input  logic                      CLK_IN,
  input  logic                      RESET_IN,

  // self-timed link side
  input  logic [`SPL_CODE_BITS-1:0] link_data,
  output logic                      link_ack,

  // synchronous packet port
  output logic [`SPL_PKT_BITS-1:0]  out_data,
  output logic                      out_vld,
  input  logic                      out_rdy
);

  localparam int CNT_BITS = $clog2(`SPL_LONG_SYMS + 1);

  receiver_state_t              state;
  logic [`SPL_CODE_BITS-1:0]    data_q;     // registered wires
  logic [`SPL_CODE_BITS-1:0]    last_seen;  // wire state of last consumed symbol
  logic [`SPL_CODE_BITS-1:0]    wire_diff;
  logic [`SPL_PKT_BITS-1:0]     asm_buf;    // packet being rebuilt
  logic [CNT_BITS-1:0]          sym_cnt;    // nibble slot for next data symbol

  symbol_kind_t                 sym_kind;
  logic [`SPL_SYM_BITS-1:0]     sym_value;
  logic                         can_act;
  logic                         take;
  logic                         take_eop;
  logic                         take_data;

  // ----------------------------------------------------------
  // transition detect and decode
  // ----------------------------------------------------------
  always_comb begin
    wire_diff = data_q ^ last_seen;
    sym_kind  = decode_2of7(wire_diff, sym_value);
  end

  assign out_vld = (state == RCV_HOLD);

  // output slot free now or freed on this edge
  assign can_act   = !out_vld || out_rdy;
  assign take      = (sym_kind != SYM_NONE) && can_act;  // illegal codes never acked
  assign take_eop  = take && (sym_kind == SYM_EOP);
  assign take_data = take && (sym_kind == SYM_DATA);

  // ----------------------------------------------------------
  // link capture and ack
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      data_q    <= '0;
      last_seen <= '0;  // matches sender reset level
      link_ack  <= 1'b0;
    end else begin
      data_q <= link_data;  // one cycle to see a change
      if (take) begin
        last_seen <= data_q;     // symbol consumed
        link_ack  <= ~link_ack;  // toggle per symbol
      end
    end
  end

  // ----------------------------------------------------------
  // reassembly and output fsm
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state   <= RCV_COLLECT;
      asm_buf <= '0;  // upper bits of a short packet read as zero
      sym_cnt <= '0;
    end else begin
      if (take_eop) begin
        state   <= RCV_HOLD;  // packet complete
        asm_buf <= '0;
        sym_cnt <= '0;
      end else begin
        if (out_vld && out_rdy) begin
          state <= RCV_COLLECT;  // delivered
        end
        if (take_data && (sym_cnt < CNT_BITS'(`SPL_LONG_SYMS))) begin
          // lsb nibble first
          asm_buf[int'(sym_cnt) * `SPL_SYM_BITS +: `SPL_SYM_BITS] <= sym_value;
          sym_cnt <= sym_cnt + 1'b1;
        end
      end
    end
  end

  // output register, loaded only on eop so it holds while out_vld is high
  always_ff @(posedge CLK_IN) begin
    if (take_eop) begin
      out_data <= asm_buf;
    end
  end

endmodule

// ==== src/spinnlink_sender.sv ====
// link transmitter, takes packets on a valid/ready port and sends them as 2-of-7 symbols
`timescale 1ns/10ps
`include "spinnlink_settings.svh"

module spinnlink_sender
  import spinnlink_pkg::*;
(
  input  logic                      CLK_IN,
  input  logic                      RESET_IN,

  // synchronous packet port
  input  logic [`SPL_PKT_BITS-1:0]  pkt_data,
  input  logic                      pkt_vld,
  output logic                      pkt_rdy,

  // self-timed link side
  output logic [`SPL_CODE_BITS-1:0] link_data,
  input  logic                      link_ack
);

  localparam int CNT_BITS = $clog2(`SPL_LONG_SYMS + 1);

  sender_state_t                state;
  logic [`SPL_PKT_BITS-1:0]     pkt_buf;     // nibbles still to send
  logic [CNT_BITS-1:0]          symbol_cnt;  // data symbols sent so far
  logic                         long_pkt;
  logic                         old_ack;     // ack level at last send

  logic                         pkt_accept;
  logic                         acked;
  logic                         eop;
  logic [`SPL_SYM_BITS-1:0]     new_nibble;
  logic [`SPL_SYM_BITS-1:0]     buf_nibble;

  // ----------------------------------------------------------
  // handshake decode
  // ----------------------------------------------------------
  assign pkt_accept = pkt_vld && pkt_rdy;
  assign acked      = (old_ack != link_ack);  // receiver toggled

  // last data symbol already out, eop goes next
  assign eop = long_pkt ? (symbol_cnt == CNT_BITS'(`SPL_LONG_SYMS))
                        : (symbol_cnt == CNT_BITS'(`SPL_SHORT_SYMS));

  assign new_nibble = pkt_data[`SPL_SYM_BITS-1:0];  // first nibble of incoming packet
  assign buf_nibble = pkt_buf[`SPL_SYM_BITS-1:0];

  // ----------------------------------------------------------
  // control fsm and link wires
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state      <= SND_IDLE;
      pkt_rdy    <= 1'b0;
      link_data  <= '0;
      old_ack    <= 1'b0;
      symbol_cnt <= '0;
      long_pkt   <= 1'b0;
    end else begin
      case (state)
        SND_IDLE: begin
          pkt_rdy <= !pkt_accept;  // drop for the packet in flight
          if (pkt_accept) begin
            link_data  <= encode_2of7(link_data, new_nibble, 1'b0);
            old_ack    <= link_ack;
            symbol_cnt <= CNT_BITS'(1);
            long_pkt   <= pkt_data[`SPL_SIZE_BIT];
            state      <= SND_TRAN;
          end
        end

        SND_TRAN: begin
          if (acked) begin
            link_data  <= encode_2of7(link_data, buf_nibble, eop);  // nibble or eop
            old_ack    <= link_ack;
            symbol_cnt <= symbol_cnt + 1'b1;
            if (eop) begin
              pkt_rdy <= 1'b1;  // open for the next packet early
              state   <= SND_EOP;
            end
          end
        end

        SND_EOP: begin
          pkt_rdy <= !pkt_accept;
          if (acked) begin
            old_ack <= link_ack;
            if (pkt_accept) begin
              // eop done, start new packet straight away
              link_data  <= encode_2of7(link_data, new_nibble, 1'b0);
              symbol_cnt <= CNT_BITS'(1);
              long_pkt   <= pkt_data[`SPL_SIZE_BIT];
              state      <= SND_TRAN;
            end else begin
              state <= SND_IDLE;
            end
          end else if (pkt_accept) begin
            state <= SND_PARK;  // packet waits in pkt_buf
          end
        end

        SND_PARK: begin
          if (acked) begin
            link_data  <= encode_2of7(link_data, buf_nibble, 1'b0);
            old_ack    <= link_ack;
            symbol_cnt <= CNT_BITS'(1);
            long_pkt   <= pkt_buf[`SPL_SIZE_BIT];
            state      <= SND_TRAN;
          end
        end

        default: state <= SND_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // packet shift buffer
  // ----------------------------------------------------------
  always_ff @(posedge CLK_IN) begin
    case (state)
      SND_IDLE: begin
        if (pkt_accept) begin
          pkt_buf <= pkt_data >> `SPL_SYM_BITS;  // first nibble already sent
        end
      end

      SND_TRAN,
      SND_PARK: begin
        if (acked) begin
          pkt_buf <= pkt_buf >> `SPL_SYM_BITS;
        end
      end

      SND_EOP: begin
        if (pkt_accept) begin
          // park whole packet unless the eop ack is here already
          pkt_buf <= acked ? (pkt_data >> `SPL_SYM_BITS) : pkt_data;
        end
      end

      default: begin
        pkt_buf <= pkt_buf;
      end
    endcase
  end

endmodule

// ==== src/spinnlink_settings.svh ====
// packet and symbol size macros for the spinnlink link, included by every source that needs them
`ifndef SPINNLINK_SETTINGS_SVH
`define SPINNLINK_SETTINGS_SVH

// packet bus, a short packet uses only the low 40 bits
`define SPL_PKT_BITS    72

// data symbols per packet, end-of-packet symbol not counted
`define SPL_SHORT_SYMS  10
`define SPL_LONG_SYMS   18

// symbol and wire widths
`define SPL_SYM_BITS    4   // one nibble per symbol
`define SPL_CODE_BITS   7   // 2-of-7 wires

// header bit that marks a long packet
`define SPL_SIZE_BIT    1

`endif
